// ==== dv/radio_frontend_tb.sv ====
/*
   testbench for radio_frontend, tx dac path and shared spi port
   dac monitor pairs an i word (sync low) with the q word one cycle later
   spi slave models run on the falling clk_fpga edge, miso idles high
*/
module radio_frontend_tb
   import radio_pkg::*, spi_pkg::*;
();

   localparam int TX_N    = 12;
   localparam int SPI_N   = 4;
   localparam int SPI_LAT = 67;                      // handshake cycle to rsp_valid cycle
   localparam int LIMIT   = TX_N * 8 + SPI_N * 80 + 100;

   typedef struct packed {
      sample_t i;
      sample_t q;
      logic    stall;
   } tx_vec_t;

   typedef struct packed {
      spi_slave_t slave;
      spi_word_t  cmd;
      spi_word_t  reply;
   } spi_vec_t;

   //////////////////////////////////////////////////
   // stimulus tables

   tx_vec_t tx_tab [TX_N] = '{
      '{16'sd1000,   -16'sd1000,  1'b1},   // mid range
      '{16'sd5,      -16'sd5,     1'b0},
      '{16'sd2,      -16'sd2,     1'b0},   // half lsb rounds up
      '{16'sd1,      -16'sd3,     1'b0},
      '{16'sd32767,  -16'sd32768, 1'b1},   // full scale, clamps
      '{16'sd32766,  -16'sd32767, 1'b0},
      '{16'sd12345,  -16'sd23456, 1'b0},
      '{16'sd0,      16'sd0,      1'b1},
      '{-16'sd1,     16'sd32764,  1'b0},
      '{16'sd4097,   -16'sd4097,  1'b0},
      '{16'sd21845,  -16'sd21846, 1'b1},
      '{-16'sd32768, 16'sd32767,  1'b0}
   };

   spi_vec_t spi_tab [SPI_N] = '{
      '{SLAVE_CODEC, 16'hA53C, 16'h3C5A},
      '{SLAVE_DB_TX, 16'h8001, 16'h7FFE},
      '{SLAVE_CGEN,  16'h1234, 16'hFEDC},
      '{SLAVE_DB_RX, 16'hFFFF, 16'h0000}    // zeros against idle-high miso
   };

   logic                  clk_fpga = 1'b0;
   logic                  reset;
   sample_t               s_i;
   sample_t               s_q;
   logic                  s_valid;
   logic                  s_ready;
   dac_word_t             tx_data;
   logic                  tx_sync;
   logic                  tx_blank;
   spi_slave_t            cmd_slave;
   spi_word_t             cmd_data;
   logic                  cmd_valid;
   logic                  cmd_ready;
   spi_word_t             rsp_data;
   logic                  rsp_valid;
   logic [NUM_SLAVES-1:0] sclk;
   logic [NUM_SLAVES-1:0] sen;
   logic [NUM_SLAVES-1:0] mosi;
   logic [NUM_SLAVES-1:0] miso = '1;

   int         checks = 0;
   int         errors = 0;
   int         cycles = 0;
   logic [15:0] lfsr  = 16'd54054;

   // dac monitor state
   int   i_seen [$];
   int   q_seen [$];
   logic joined [$];                                 // pair followed a q with no blank
   int   bus_faults = 0;
   logic have_i = 1'b0;
   logic prev_q = 1'b0;

   // spi slave model state, index = slave
   spi_word_t             reply_word [NUM_SLAVES];
   spi_word_t             miso_shift [NUM_SLAVES];
   spi_word_t             cap_word   [NUM_SLAVES];
   int                    rise_cnt   [NUM_SLAVES] = '{default: 0};
   int                    edge_cnt   [NUM_SLAVES] = '{default: 0};
   int                    low_cnt    [NUM_SLAVES] = '{default: 0};
   int                    mosi_cnt   [NUM_SLAVES] = '{default: 0};
   logic [NUM_SLAVES-1:0] sclk_prev = '0;
   logic [NUM_SLAVES-1:0] sen_prev  = '1;

   always #4 clk_fpga = ~clk_fpga;                   // 8 unit period

   radio_frontend u_radio_frontend (
      .clk_fpga  (clk_fpga),
      .reset     (reset),
      .s_i       (s_i),
      .s_q       (s_q),
      .s_valid   (s_valid),
      .s_ready   (s_ready),
      .tx_data   (tx_data),
      .tx_sync   (tx_sync),
      .tx_blank  (tx_blank),
      .cmd_slave (cmd_slave),
      .cmd_data  (cmd_data),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .rsp_data  (rsp_data),
      .rsp_valid (rsp_valid),
      .sclk      (sclk),
      .sen       (sen),
      .mosi      (mosi),
      .miso      (miso)
   );

   //////////////////////////////////////////////////
   // helpers

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic random_bits(input int n, output int val);
      val = 0;
      for (int b = 0; b < n; b++)
      begin
         lfsr = lfsr_next(lfsr);                     // one step per bit
         val  = (val << 1) | lfsr[0];
      end
   endtask

   // dac code from the rounding rule, half lsb up then floor, clamp to 14 bits
   function automatic int dac_expect(input int x);
      int r;
      r = (x + 2) >>> 2;
      if (r > 8191)
         r = 8191;
      else if (r < -8192)
         r = -8192;
      return r;
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      checks++;
      assert (expected == actual)
      else
      begin
         errors++;
         $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_true(input logic ok, input string what);
      checks++;
      assert (ok === 1'b1)
      else
      begin
         errors++;
         $display("ERROR: %s", what);
      end
   endtask

   //////////////////////////////////////////////////
   // dac monitor and spi slave models

   always @(negedge clk_fpga)
   begin
      if (reset === 1'b0)
      begin
         if (tx_blank && (tx_data != '0 || tx_sync))
            bus_faults++;                            // blank bus must be quiet
         if (have_i)
         begin
            if (!tx_sync || tx_blank)
               bus_faults++;                         // i with no q after it
            else
               q_seen.push_back(int'(tx_data));
            have_i = 1'b0;
         end
         else if (!tx_blank && !tx_sync)
         begin
            i_seen.push_back(int'(tx_data));
            joined.push_back(prev_q);
            have_i = 1'b1;
         end
         else if (tx_sync)
            bus_faults++;                            // q with no i before it
         prev_q = tx_sync && !tx_blank;
      end
   end

   always @(negedge clk_fpga)
   begin
      for (int k = 0; k < NUM_SLAVES; k++)
      begin
         if (!sen[k] && sen_prev[k])
            miso_shift[k] = reply_word[k];           // sen fell, msb out first
         else if (!sclk[k] && sclk_prev[k])
            miso_shift[k] = miso_shift[k] << 1;      // falling sclk
         if (sclk[k] && !sclk_prev[k])
         begin
            cap_word[k] = {cap_word[k][14:0], mosi[k]};
            rise_cnt[k]++;
         end
         if (sclk[k] !== sclk_prev[k])
            edge_cnt[k]++;
         if (!sen[k])
            low_cnt[k]++;
         if (mosi[k] !== 1'b0)
            mosi_cnt[k]++;
         miso[k] = sen[k] ? 1'b1 : miso_shift[k][15];
      end
      sclk_prev = sclk;
      sen_prev  = sen;
   end

   //////////////////////////////////////////////////
   // stimulus

   task automatic send_tx_table();
      int gap;
      for (int n = 0; n < TX_N; n++)
      begin
         if (tx_tab[n].stall)
         begin
            s_valid = 1'b0;
            random_bits(2, gap);
            repeat (gap + 1) @(negedge clk_fpga);    // idle gap
         end
         s_i     = tx_tab[n].i;
         s_q     = tx_tab[n].q;
         s_valid = 1'b1;
         while (s_ready !== 1'b1)
            @(negedge clk_fpga);
         @(negedge clk_fpga);                        // taken on the edge before
      end
      s_valid = 1'b0;
   endtask

   task automatic run_spi(input int n);
      int         gap;
      int         lat;
      int         rise0 [NUM_SLAVES];
      int         edge0 [NUM_SLAVES];
      int         low0  [NUM_SLAVES];
      int         mosi0 [NUM_SLAVES];
      spi_slave_t sl;
      sl = spi_tab[n].slave;
      random_bits(3, gap);
      repeat (gap) @(negedge clk_fpga);
      reply_word[sl] = spi_tab[n].reply;
      for (int k = 0; k < NUM_SLAVES; k++)
      begin
         rise0[k] = rise_cnt[k];
         edge0[k] = edge_cnt[k];
         low0[k]  = low_cnt[k];
         mosi0[k] = mosi_cnt[k];
      end
      cmd_slave = sl;
      cmd_data  = spi_tab[n].cmd;
      cmd_valid = 1'b1;
      while (cmd_ready !== 1'b1)
         @(negedge clk_fpga);
      @(negedge clk_fpga);
      cmd_valid = 1'b0;
      lat = 1;
      while (rsp_valid !== 1'b1)
      begin
         @(negedge clk_fpga);
         lat++;
      end
      check_value($sformatf("spi %0d latency", n), SPI_LAT, lat);
      check_value($sformatf("spi %0d rsp_data", n), int'(spi_tab[n].reply), int'(rsp_data));
      for (int k = 0; k < NUM_SLAVES; k++)
      begin
         if (k == int'(sl))
         begin
            check_value($sformatf("spi %0d slave %0d mosi word", n, k),
                        int'(spi_tab[n].cmd), int'(cap_word[k]));
            check_value($sformatf("spi %0d slave %0d sclk rises", n, k),
                        16, rise_cnt[k] - rise0[k]);
         end
         else
         begin
            check_true(edge_cnt[k] == edge0[k],
                       $sformatf("spi %0d: sclk toggled on unselected slave %0d", n, k));
            check_true(low_cnt[k] == low0[k],
                       $sformatf("spi %0d: sen went low on unselected slave %0d", n, k));
            check_true(mosi_cnt[k] == mosi0[k],
                       $sformatf("spi %0d: mosi went high on unselected slave %0d", n, k));
         end
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence

   initial
   begin
      reset     = 1'b1;
      s_i       = '0;
      s_q       = '0;
      s_valid   = 1'b0;
      cmd_slave = SLAVE_DB_TX;
      cmd_data  = '0;
      cmd_valid = 1'b0;
      repeat (5) @(negedge clk_fpga);
      reset = 1'b0;
      // state right after reset, nothing driven yet
      check_value("tx_blank after reset", 1, tx_blank);
      check_value("tx_sync after reset", 0, tx_sync);
      check_value("sen after reset", 15, sen);
      check_value("sclk after reset", 0, sclk);
      check_value("mosi after reset", 0, mosi);
      check_value("cmd_ready after reset", 1, cmd_ready);
      check_value("rsp_valid after reset", 0, rsp_valid);
      check_value("s_ready first cycle", 0, s_ready);
      @(negedge clk_fpga);
      check_value("s_ready second cycle", 1, s_ready);

      fork
         send_tx_table();
         begin
            for (int n = 0; n < SPI_N; n++)
               run_spi(n);
         end
      join

      while (q_seen.size() < TX_N)
         @(negedge clk_fpga);
      repeat (4) @(negedge clk_fpga);                // room for stray pairs
      check_value("tx pair count", TX_N, q_seen.size());
      check_value("dac bus framing faults", 0, bus_faults);
      for (int n = 0; n < TX_N && n < q_seen.size(); n++)
      begin
         check_value($sformatf("tx pair %0d i", n), dac_expect($signed(tx_tab[n].i)), i_seen[n]);
         check_value($sformatf("tx pair %0d q", n), dac_expect($signed(tx_tab[n].q)), q_seen[n]);
         if (n > 0 && !tx_tab[n].stall)
            check_true(joined[n], $sformatf("dac bus gap before back-to-back pair %0d", n));
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // run limit, sized from the table lengths
   always @(posedge clk_fpga)
   begin
      cycles++;
      if (cycles >= LIMIT)
      begin
         $display("ERROR: timeout after %0d cycles, the DUT stopped responding", cycles);
         $display("checks %0d, errors %0d", checks, errors + 1);
         $display("test failed");
         $finish;
      end
   end

endmodule

// ==== list.f ====
verilog/radio_pkg.sv
verilog/spi_pkg.sv
verilog/tx_sample_if.sv
verilog/tx_skid_buffer.sv
verilog/tx_dac_formatter.sv
verilog/dac_interleaver.sv
verilog/spi_master.sv
verilog/radio_frontend.sv
dv/radio_frontend_tb.sv

// ==== verilog/dac_interleaver.sv ====
/*
   drives i then q on the single 14 bit dac bus, one word per clock
   a sample occupies two cycles, so the path sustains half the clock rate
   tx_sync marks q, tx_blank marks an empty bus (data forced to zero)
*/
module dac_interleaver
   import radio_pkg::*;
(
   input  logic      clk_fpga,
   input  logic      reset,
   tx_sample_if.sink s,
   output dac_word_t tx_data,
   output logic      tx_sync,
   output logic      tx_blank
);

   dac_word_t hold_i;   // sample on the bus
   dac_word_t hold_q;
   logic      busy;     // holding a sample
   logic      phase;    // 0 = showing i, 1 = showing q
   logic      take;

   // next sample can load during the q word, no gap between pairs
   assign s.ready = !busy || phase;
   assign take    = s.valid && s.ready;

   //////////////////////////////////////////////////
   // phase tracking

   always_ff @(posedge clk_fpga)
   begin
      if (reset)
      begin
         busy  <= 1'b0;
         phase <= 1'b0;
      end
      else if (take)
      begin
         busy  <= 1'b1;
         phase <= 1'b0;       // i goes out next
      end
      else if (busy && !phase)
         phase <= 1'b1;       // i done, q next
      else
      begin
         busy  <= 1'b0;       // q done and nothing waiting
         phase <= 1'b0;
      end
   end

   always_ff @(posedge clk_fpga)
   begin
      if (take)
      begin
         hold_i <= s.i;
         hold_q <= s.q;
      end
   end

   //////////////////////////////////////////////////
   // dac bus

   assign tx_blank = !busy;
   assign tx_sync  = busy && phase;
   assign tx_data  = !busy ? '0 : (phase ? hold_q : hold_i);

   // every q word is preceded by its i word
   a_sync_alternates: assert property (@(posedge clk_fpga) disable iff (reset)
      tx_sync && !tx_blank |=> !tx_sync || tx_blank);

endmodule

// ==== verilog/radio_frontend.sv ====
/*
   tx sample output and spi control port of the radio front end
   dac bus is single data rate, so one sample takes two clk_fpga cycles
   tx latency is 3 cycles from accept to the i word when the path is empty
*/
module radio_frontend
   import radio_pkg::*, spi_pkg::*;
(
   input  logic                  clk_fpga,
   input  logic                  reset,
   // host samples
   input  sample_t               s_i,
   input  sample_t               s_q,
   input  logic                  s_valid,
   output logic                  s_ready,
   // dac bus
   output dac_word_t             tx_data,
   output logic                  tx_sync,
   output logic                  tx_blank,
   // spi command/response
   input  spi_slave_t            cmd_slave,
   input  spi_word_t             cmd_data,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   output spi_word_t             rsp_data,
   output logic                  rsp_valid,
   // spi pins, bit k = slave k
   output logic [NUM_SLAVES-1:0] sclk,
   output logic [NUM_SLAVES-1:0] sen,
   output logic [NUM_SLAVES-1:0] mosi,
   input  logic [NUM_SLAVES-1:0] miso
);

   //////////////////////////////////////////////////
   // tx pipeline

   tx_sample_if #(.payload_t(sample_t))   skid_to_fmt ();   // full width samples
   tx_sample_if #(.payload_t(dac_word_t)) fmt_to_ilv ();    // dac codes

   tx_skid_buffer u_skid (
      .clk_fpga (clk_fpga),
      .reset    (reset),
      .s_i      (s_i),
      .s_q      (s_q),
      .s_valid  (s_valid),
      .s_ready  (s_ready),
      .m        (skid_to_fmt.source)
   );

   tx_dac_formatter u_fmt (
      .clk_fpga (clk_fpga),
      .reset    (reset),
      .s        (skid_to_fmt.sink),
      .m        (fmt_to_ilv.source)
   );

   dac_interleaver u_ilv (
      .clk_fpga (clk_fpga),
      .reset    (reset),
      .s        (fmt_to_ilv.sink),
      .tx_data  (tx_data),
      .tx_sync  (tx_sync),
      .tx_blank (tx_blank)
   );

   //////////////////////////////////////////////////
   // spi, independent of the tx path

   spi_master u_spi (
      .clk_fpga  (clk_fpga),
      .reset     (reset),
      .cmd_slave (cmd_slave),
      .cmd_data  (cmd_data),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .rsp_data  (rsp_data),
      .rsp_valid (rsp_valid),
      .sclk      (sclk),
      .sen       (sen),
      .mosi      (mosi),
      .miso      (miso)
   );

endmodule

// ==== verilog/radio_pkg.sv ====
/*
   types and limits for the tx sample path
   host samples are 16 bit signed, the dac takes 14 bit signed codes
   DAC_MAX/DAC_MIN must match the dac_word_t width
*/
package radio_pkg;

   //////////////////////////////////////////////////
   // sample widths

   typedef logic signed [15:0] sample_t;    // one host i or q component
   typedef logic signed [13:0] dac_word_t;  // one dac code

   //////////////////////////////////////////////////
   // formatter constants

   localparam int DAC_SHIFT = 2;            // 16 -> 14 bits
   localparam int DAC_MAX   = 8191;         // largest 14 bit code
   localparam int DAC_MIN   = -8192;        // smallest 14 bit code

endpackage

// ==== verilog/spi_master.sv ====
/*
   spi master shared by four slaves, 16 bit words msb first
   sclk idles low, mosi changes on falling sclk, miso sampled on rising sclk
   only the selected slave sees sclk, mosi and a low sen
   67 clocks from command accept to rsp_valid with SPI_DIV = 2
*/
module spi_master
   import spi_pkg::*;
(
   input  logic                  clk_fpga,
   input  logic                  reset,
   input  spi_slave_t            cmd_slave,
   input  spi_word_t             cmd_data,
   input  logic                  cmd_valid,
   output logic                  cmd_ready,
   output spi_word_t             rsp_data,
   output logic                  rsp_valid,
   output logic [NUM_SLAVES-1:0] sclk,
   output logic [NUM_SLAVES-1:0] sen,     // active low
   output logic [NUM_SLAVES-1:0] mosi,
   input  logic [NUM_SLAVES-1:0] miso
);

   spi_state_t                           state;
   spi_slave_t                           slave;      // latched target
   spi_word_t                            tx_shift;   // msb drives mosi
   spi_word_t                            rx_shift;   // miso enters at lsb
   logic [$clog2(SPI_DIV)-1:0]           div_cnt;    // clocks within a half period
   logic [$clog2($bits(spi_word_t))-1:0] bit_cnt;    // falling edges, wraps after 16
   logic                                 sclk_r;
   logic                                 active;
   logic                                 half_end;
   logic                                 rise;
   logic                                 fall;
   logic                                 miso_sel;
   logic [NUM_SLAVES-1:0]                sel;

   assign cmd_ready = (state == SPI_IDLE);
   assign active    = (state == SPI_SETUP) || (state == SPI_SHIFT);
   assign half_end  = (div_cnt == SPI_DIV - 1);
   assign miso_sel  = miso[slave];                   // ignore the other lines

   // first rise leaves setup, later rises end a low half, none after bit 15
   assign rise = (state == SPI_SETUP) ||
                 ((state == SPI_SHIFT) && half_end && !sclk_r && (bit_cnt != 0));
   assign fall = (state == SPI_SHIFT) && half_end && sclk_r;

   //////////////////////////////////////////////////
   // per slave routing

   always_comb
   begin
      sel = '0;
      if (active)
         sel[slave] = 1'b1;
   end

   assign sen      = ~sel;
   assign sclk     = {NUM_SLAVES{sclk_r}} & sel;
   assign mosi     = {NUM_SLAVES{tx_shift[$bits(spi_word_t)-1]}} & sel;
   assign rsp_data = rx_shift;                       // valid with rsp_valid

   //////////////////////////////////////////////////
   // fsm and counters

   always_ff @(posedge clk_fpga)
   begin
      if (reset)
      begin
         state     <= SPI_IDLE;
         sclk_r    <= 1'b0;
         div_cnt   <= '0;
         bit_cnt   <= '0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         case (state)
            SPI_IDLE:  if (cmd_valid) state <= SPI_SETUP;
            SPI_SETUP: state <= SPI_SHIFT;
            SPI_SHIFT: if (half_end && !sclk_r && (bit_cnt == 0)) state <= SPI_DONE;
            default:   state <= SPI_IDLE;                 // done, sen already high
         endcase
         if (state == SPI_SHIFT)
            div_cnt <= half_end ? '0 : div_cnt + 1'b1;
         if (rise)
            sclk_r <= 1'b1;
         else if (fall)
            sclk_r <= 1'b0;
         if (fall)
            bit_cnt <= bit_cnt + 1'b1;
         rsp_valid <= (state == SPI_DONE);               // one cycle after sen rises
      end
   end

   always_ff @(posedge clk_fpga)
   begin
      if (cmd_valid && cmd_ready)
      begin
         tx_shift <= cmd_data;
         slave    <= cmd_slave;
      end
      else if (fall)
         tx_shift <= tx_shift << 1;                      // next bit on the low half
      if (rise)
         rx_shift <= {rx_shift[$bits(spi_word_t)-2:0], miso_sel};
   end

   // the commanded slave alone goes low once the word starts
   a_one_sen: assert property (@(posedge clk_fpga) disable iff (reset)
      cmd_valid && cmd_ready |=> (~sen == (NUM_SLAVES'(1) << $past(cmd_slave))));

   // sclk edges only inside a slave's own sen window
   for (genvar k = 0; k < NUM_SLAVES; k++)
   begin : g_sclk_chk
      a_sclk_quiet: assert property (@(posedge clk_fpga) disable iff (reset)
         sen[k] |-> $stable(sclk[k]));
   end

endmodule

// ==== verilog/spi_pkg.sv ====
/*
   types and constants for the shared spi control port
   slave enum order is also the bit order of sclk/sen/mosi/miso
   SPI_DIV counts clk_fpga cycles per sclk half period, must be >= 2
*/
package spi_pkg;

   typedef logic [15:0] spi_word_t;       // one command or reply word

   // slave index, bit k of the spi buses belongs to slave k
   typedef enum logic [1:0] {
      SLAVE_DB_TX,
      SLAVE_DB_RX,
      SLAVE_CODEC,
      SLAVE_CGEN
   } spi_slave_t;

   localparam int NUM_SLAVES = 4;
   localparam int SPI_DIV    = 2;         // sclk period = 2*SPI_DIV clocks

   typedef enum logic [1:0] {
      SPI_IDLE,                           // waiting for a command
      SPI_SETUP,                          // sen low, first bit on mosi
      SPI_SHIFT,                          // 16 sclk periods
      SPI_DONE                            // sen back high
   } spi_state_t;

endpackage

// ==== verilog/tx_dac_formatter.sv ====
/*
   rounds 16 bit samples to the 14 bit dac code
   round half up, then clamp to DAC_MIN..DAC_MAX
   one register stage, full throughput when downstream keeps up
*/
module tx_dac_formatter
   import radio_pkg::*;
(
   input  logic        clk_fpga,
   input  logic        reset,
   tx_sample_if.sink   s,
   tx_sample_if.source m
);

   // add half an lsb, arithmetic shift, saturate
   function automatic dac_word_t round_sat(input sample_t x);
      logic signed [$bits(sample_t):0] wide;   // one guard bit for +2 at full scale
      wide = {x[$bits(sample_t)-1], x};
      wide = wide + (1 <<< (DAC_SHIFT - 1));   // half lsb of the dac code
      wide = wide >>> DAC_SHIFT;
      if (wide > DAC_MAX)
         round_sat = dac_word_t'(DAC_MAX);
      else if (wide < DAC_MIN)
         round_sat = dac_word_t'(DAC_MIN);
      else
         round_sat = dac_word_t'(wide);
   endfunction

   // take a new pair when empty or when the current one leaves
   assign s.ready = !m.valid || m.ready;

   //////////////////////////////////////////////////
   // control

   always_ff @(posedge clk_fpga)
   begin
      if (reset)
         m.valid <= 1'b0;
      else if (s.ready)
         m.valid <= s.valid;
   end

   always_ff @(posedge clk_fpga)
   begin
      if (s.valid && s.ready)
      begin
         m.i <= round_sat(s.i);
         m.q <= round_sat(s.q);
      end
   end

   // clamped codes keep the sign of the input, no wrap at full scale
   a_no_wrap: assert property (@(posedge clk_fpga) disable iff (reset)
      s.valid && s.ready |=>
         (m.i == '0 || m.i[$bits(dac_word_t)-1] == $past(s.i[$bits(sample_t)-1])) &&
         (m.q == '0 || m.q[$bits(dac_word_t)-1] == $past(s.q[$bits(sample_t)-1])));

endmodule

// ==== verilog/tx_sample_if.sv ====
/*
   valid/ready link for one i/q pair between tx stages
   payload_t sets the width of i and q, so both sides must agree on it
   source holds valid and data while ready is low
*/
interface tx_sample_if #(
   parameter type payload_t = logic signed [15:0]
);

   payload_t i;      // in-phase
   payload_t q;      // quadrature
   logic     valid;
   logic     ready;

   modport source (output i, output q, output valid, input ready);
   modport sink   (input i, input q, input valid, output ready);

endinterface

// ==== verilog/tx_skid_buffer.sv ====
/*
   input stage of the tx path, two entry skid buffer
   s_ready is a register, so host timing never sees the downstream ready
   s_ready stays low in the first cycle after reset
*/
module tx_skid_buffer
   import radio_pkg::*;
(
   input  logic        clk_fpga,
   input  logic        reset,
   input  sample_t     s_i,
   input  sample_t     s_q,
   input  logic        s_valid,
   output logic        s_ready,
   tx_sample_if.source m
);

   sample_t skid_i;       // overflow entry
   sample_t skid_q;
   logic    skid_valid;
   logic    take;         // host transfer this cycle
   logic    out_free;     // main register can load
   logic    skid_load;
   logic    skid_unload;

   assign take        = s_valid && s_ready;
   assign out_free    = !m.valid || m.ready;
   assign skid_load   = take && !out_free;        // output stalled, park it
   assign skid_unload = skid_valid && out_free;   // skid moves to main

   //////////////////////////////////////////////////
   // control

   always_ff @(posedge clk_fpga)
   begin
      if (reset)
      begin
         m.valid    <= 1'b0;
         skid_valid <= 1'b0;
         s_ready    <= 1'b0;
      end
      else
      begin
         if (out_free)
            m.valid <= skid_valid || take;
         if (skid_load)
            skid_valid <= 1'b1;
         else if (skid_unload)
            skid_valid <= 1'b0;
         // ready next cycle only if skid ends up empty
         s_ready <= !(skid_load || (skid_valid && !skid_unload));
      end
   end

   //////////////////////////////////////////////////
   // payload

   always_ff @(posedge clk_fpga)
   begin
      if (out_free)
      begin
         if (skid_valid)
         begin
            m.i <= skid_i;    // older sample first
            m.q <= skid_q;
         end
         else if (take)
         begin
            m.i <= s_i;
            m.q <= s_q;
         end
      end
      if (skid_load)
      begin
         skid_i <= s_i;
         skid_q <= s_q;
      end
   end

   // stalled output must not change under the downstream stage
   a_hold_on_stall: assert property (@(posedge clk_fpga) disable iff (reset)
      m.valid && !m.ready |=> m.valid && $stable(m.i) && $stable(m.q));

endmodule
